// File: build.f
common/lane_arb_pkg.sv
sldu_arb/sldu_order_tracker.sv
sldu_arb/sldu_sel_fifo.sv
sldu_arb/sldu_operand_router.sv
design/lane_sldu_arb.sv
tb/lane_sldu_arb_checker.sv
tb/lane_sldu_arb_tb.sv

// File: Makefile
# Verilator build and run of the lane operand bus arbiter testbench

VERILATOR ?= verilator
TOP       ?= lane_sldu_arb_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failures"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi; \
	echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/lane_sldu_arb_tb.sv
// Table-driven testbench for the lane operand bus arbiter; top module of the simulation

`timescale 1ns/1ps

module lane_sldu_arb_tb;

  localparam int unsigned DataWidth = lane_arb_pkg::ElenWidth;
  localparam int NumRows       = 10;
  localparam int ResetCycles   = 5;
  localparam int TimeoutCycles = NumRows * 20 + ResetCycles;
  localparam int KindNone      = -1;
  localparam int KindSldu      = int'(lane_arb_pkg::sel_sldu);
  localparam int KindAddr      = int'(lane_arb_pkg::sel_addrgen);
  localparam int KindAlu       = int'(lane_arb_pkg::sel_alu_red);
  localparam int KindFpu       = int'(lane_arb_pkg::sel_fpu_red);

  logic clk = 1'b0;
  logic rst_i, flush_i, vfu_op_valid_i, cmd_pop_i, alu_red_complete_i, fpu_red_complete_i;
  lane_arb_pkg::ara_op_e vfu_op_i;
  logic [DataWidth-1:0] opq_operand_i, alu_red_data_i, fpu_red_data_i, sldu_operand_o;
  logic opq_valid_i, alu_red_valid_i, fpu_red_valid_i, sldu_operand_ready_i;
  logic addrgen_operand_ready_i, sldu_red_valid_i, sldu_result_gnt_opq_i;
  logic sldu_alu_ready_i, sldu_mfpu_ready_i;
  logic opq_ready_o, alu_red_gnt_o, fpu_red_gnt_o, sldu_operand_valid_o;
  logic addrgen_operand_valid_o, sldu_result_gnt_o, sldu_alu_valid_o, sldu_mfpu_valid_o;
  integer seed;
  int errors = 0;

  // One row per op: code and the route kind it must claim
  lane_arb_pkg::ara_op_e row_op [NumRows] = '{
    lane_arb_pkg::vslideup, lane_arb_pkg::vslidedown, lane_arb_pkg::vlxe, lane_arb_pkg::vsxe,
    lane_arb_pkg::vredsum, lane_arb_pkg::vwredsum, lane_arb_pkg::vfredusum,
    lane_arb_pkg::vfwredosum, lane_arb_pkg::vadd, lane_arb_pkg::vredmax};
  int row_kind [NumRows] = '{KindSldu, KindSldu, KindAddr, KindAddr, KindAlu, KindAlu,
                             KindFpu, KindFpu, KindNone, KindAlu};

  lane_sldu_arb dut0 (.clk_i(clk), .*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %0d ns %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [DataWidth-1:0] exp,
                            input logic [DataWidth-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // Expected bus state for a head kind, built from the driven inputs
  task automatic check_route(input int kind);
    logic [DataWidth-1:0] e_data;
    logic e_sv, e_av, e_rdy, e_agnt, e_fgnt, e_alu, e_mfpu, e_res;
    {e_sv, e_av, e_rdy, e_agnt, e_fgnt, e_alu, e_mfpu, e_res} = '0;
    e_data = opq_operand_i;
    case (kind)
      KindSldu: begin
        e_sv  = opq_valid_i;
        e_rdy = sldu_operand_ready_i;
        e_res = sldu_result_gnt_opq_i;
      end
      KindAddr: begin
        e_av  = opq_valid_i;
        e_rdy = addrgen_operand_ready_i;
      end
      KindAlu: begin
        e_data = alu_red_data_i;
        e_sv   = alu_red_valid_i;
        e_agnt = sldu_operand_ready_i;
        e_alu  = sldu_red_valid_i;
        e_res  = sldu_alu_ready_i;
      end
      KindFpu: begin
        e_data = fpu_red_data_i;
        e_sv   = fpu_red_valid_i;
        e_fgnt = sldu_operand_ready_i;
        e_mfpu = sldu_red_valid_i;
        e_res  = sldu_mfpu_ready_i;
      end
      default: begin
      end
    endcase
    if (kind != KindNone) begin
      check_word("sldu_operand_o", e_data, sldu_operand_o);
    end
    check_bit("sldu_operand_valid_o", e_sv, sldu_operand_valid_o);
    check_bit("addrgen_operand_valid_o", e_av, addrgen_operand_valid_o);
    check_bit("opq_ready_o", e_rdy, opq_ready_o);
    check_bit("alu_red_gnt_o", e_agnt, alu_red_gnt_o);
    check_bit("fpu_red_gnt_o", e_fgnt, fpu_red_gnt_o);
    check_bit("sldu_alu_valid_o", e_alu, sldu_alu_valid_o);
    check_bit("sldu_mfpu_valid_o", e_mfpu, sldu_mfpu_valid_o);
    check_bit("sldu_result_gnt_o", e_res, sldu_result_gnt_o);
  endtask

  // Random sources; stall forces valids high and bus readies low
  task automatic drive_sources(input logic stall);
    logic [31:0] r;
    r = $random(seed);
    opq_operand_i           <= {$random(seed), $random(seed)};
    alu_red_data_i          <= {$random(seed), $random(seed)};
    fpu_red_data_i          <= {$random(seed), $random(seed)};
    opq_valid_i             <= r[0] | stall;
    alu_red_valid_i         <= r[1] | stall;
    fpu_red_valid_i         <= r[2] | stall;
    sldu_operand_ready_i    <= r[3] & ~stall;
    addrgen_operand_ready_i <= r[4] & ~stall;
    sldu_red_valid_i        <= r[5];
    sldu_result_gnt_opq_i   <= r[6];
    sldu_alu_ready_i        <= r[7];
    sldu_mfpu_ready_i       <= r[8];
  endtask

  task automatic issue_op(input lane_arb_pkg::ara_op_e op);
    @(posedge clk);
    vfu_op_valid_i <= 1'b1;
    vfu_op_i       <= op;
    drive_sources(1'b0);
  endtask

  // Ends the op stream and waits until the last op sits in the FIFO
  task automatic settle_ops();
    @(posedge clk);
    vfu_op_valid_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic pulse_complete(input int kind);
    @(posedge clk);
    cmd_pop_i          <= (kind == KindSldu) || (kind == KindAddr);
    alu_red_complete_i <= (kind == KindAlu);
    fpu_red_complete_i <= (kind == KindFpu);
    @(posedge clk);
    cmd_pop_i          <= 1'b0;
    alu_red_complete_i <= 1'b0;
    fpu_red_complete_i <= 1'b0;
    @(negedge clk);
  endtask

  function automatic int mismatched_kind(input int kind);
    if (kind == KindAlu) return KindFpu;
    if (kind == KindFpu) return KindSldu;
    return KindAlu;
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int route_q[$];
    seed = 26;
    {flush_i, vfu_op_valid_i, cmd_pop_i, alu_red_complete_i, fpu_red_complete_i} = '0;
    vfu_op_i = lane_arb_pkg::vadd;
    {opq_operand_i, alu_red_data_i, fpu_red_data_i} = '0;
    {opq_valid_i, alu_red_valid_i, fpu_red_valid_i, sldu_operand_ready_i} = '0;
    {addrgen_operand_ready_i, sldu_red_valid_i, sldu_result_gnt_opq_i} = '0;
    {sldu_alu_ready_i, sldu_mfpu_ready_i} = '0;
    rst_i = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_route(KindNone);

    // Each row alone, then under back-pressure, then retired
    for (int i = 0; i < NumRows; i++) begin
      issue_op(row_op[i]);
      settle_ops();
      check_route(row_kind[i]);
      @(posedge clk);
      drive_sources(1'b1);
      @(negedge clk);
      check_route(row_kind[i]);
      if (row_kind[i] != KindNone) begin
        pulse_complete(row_kind[i]);
        check_route(KindNone);
      end
    end

    // Issue order across three kinds
    issue_op(lane_arb_pkg::vlxe);
    route_q.push_back(KindAddr);
    issue_op(lane_arb_pkg::vfredosum);
    route_q.push_back(KindFpu);
    issue_op(lane_arb_pkg::vslidedown);
    route_q.push_back(KindSldu);
    settle_ops();
    while (route_q.size() > 0) begin
      check_route(route_q[0]);
      pulse_complete(mismatched_kind(route_q[0]));
      check_route(route_q[0]);
      pulse_complete(route_q[0]);
      void'(route_q.pop_front());
    end
    check_route(KindNone);

    // Flush with two entries queued
    issue_op(lane_arb_pkg::vsxe);
    issue_op(lane_arb_pkg::vredand);
    settle_ops();
    check_route(KindAddr);
    @(posedge clk);
    flush_i <= 1'b1;
    drive_sources(1'b1);
    @(posedge clk);
    flush_i <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_route(KindNone);
    end

    $display("Check errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: tb/lane_sldu_arb_checker.sv
// Bound assertions on the selector FIFO and the shared bus valids; compiled with the testbench

`timescale 1ns/1ps

module lane_sldu_arb_checker (
  input logic clk_i,
  input logic rst_i,
  input logic push_i,
  input logic pop_i,
  input logic full_i,
  input logic head_valid_i,
  input logic sldu_valid_i,
  input logic addrgen_valid_i
);

  // In-flight limit keeps the FIFO from overflowing
  no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
    !(push_i && full_i))
    else $error("selector FIFO pushed while full");

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    !(pop_i && !head_valid_i))
    else $error("selector FIFO popped while empty");

  // Slide unit and address generator never share a cycle on the bus
  one_bus_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    !(sldu_valid_i && addrgen_valid_i))
    else $error("slide unit and address generator valids high together");

endmodule

////////////////////////////////////////////////////////////
// Attachments
////////////////////////////////////////////////////////////

// FIFO handshake and router outputs, all visible in the top level
bind lane_sldu_arb lane_sldu_arb_checker u_arb_checker (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .push_i          (push),
  .pop_i           (pop),
  .full_i          (full),
  .head_valid_i    (head_valid),
  .sldu_valid_i    (sldu_operand_valid_o),
  .addrgen_valid_i (addrgen_operand_valid_o)
);

// File: design/lane_sldu_arb.sv
// Lane arbiter top for the operand bus shared by slide unit and address generator

`timescale 1ns/1ps

module lane_sldu_arb #(
  parameter int unsigned DataWidth = lane_arb_pkg::ElenWidth,
  parameter int unsigned FifoDepth = lane_arb_pkg::NrVInsn
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Issued vector operation
  input  logic                  vfu_op_valid_i,
  input  lane_arb_pkg::ara_op_e vfu_op_i,
  // Completion strobes
  input  logic                  cmd_pop_i,
  input  logic                  alu_red_complete_i,
  input  logic                  fpu_red_complete_i,
  // Operand queue
  input  logic [DataWidth-1:0]  opq_operand_i,
  input  logic                  opq_valid_i,
  output logic                  opq_ready_o,
  // Reduction results
  input  logic [DataWidth-1:0]  alu_red_data_i,
  input  logic                  alu_red_valid_i,
  output logic                  alu_red_gnt_o,
  input  logic [DataWidth-1:0]  fpu_red_data_i,
  input  logic                  fpu_red_valid_i,
  output logic                  fpu_red_gnt_o,
  // Shared operand bus
  output logic [DataWidth-1:0]  sldu_operand_o,
  output logic                  sldu_operand_valid_o,
  input  logic                  sldu_operand_ready_i,
  output logic                  addrgen_operand_valid_o,
  input  logic                  addrgen_operand_ready_i,
  // Slide unit
  input  logic                  sldu_red_valid_i,
  input  logic                  sldu_result_gnt_opq_i,
  input  logic                  sldu_alu_ready_i,
  input  logic                  sldu_mfpu_ready_i,
  output logic                  sldu_result_gnt_o,
  output logic                  sldu_alu_valid_o,
  output logic                  sldu_mfpu_valid_o
);

  logic                     push;
  lane_arb_pkg::route_sel_e push_sel;
  logic                     head_valid;
  lane_arb_pkg::route_sel_e head_sel;
  logic                     pop;
  logic                     full;

  ////////////////////////////////////////////////////////////
  // Issue order capture
  ////////////////////////////////////////////////////////////

  sldu_order_tracker u_tracker (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .vfu_op_valid_i (vfu_op_valid_i),
    .vfu_op_i       (vfu_op_i),
    .push_o         (push),
    .push_sel_o     (push_sel)
  );

  // Full flag is only watched by the bound checker
  sldu_sel_fifo #(
    .FifoDepth (FifoDepth)
  ) u_sel_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .push_i       (push),
    .push_sel_i   (push_sel),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_sel_o   (head_sel),
    .full_o       (full)
  );

  ////////////////////////////////////////////////////////////
  // Bus steering
  ////////////////////////////////////////////////////////////

  sldu_operand_router #(
    .DataWidth (DataWidth)
  ) u_router (
    .head_valid_i            (head_valid),
    .head_sel_i              (head_sel),
    .cmd_pop_i               (cmd_pop_i),
    .alu_red_complete_i      (alu_red_complete_i),
    .fpu_red_complete_i      (fpu_red_complete_i),
    .opq_operand_i           (opq_operand_i),
    .opq_valid_i             (opq_valid_i),
    .opq_ready_o             (opq_ready_o),
    .alu_red_data_i          (alu_red_data_i),
    .alu_red_valid_i         (alu_red_valid_i),
    .alu_red_gnt_o           (alu_red_gnt_o),
    .fpu_red_data_i          (fpu_red_data_i),
    .fpu_red_valid_i         (fpu_red_valid_i),
    .fpu_red_gnt_o           (fpu_red_gnt_o),
    .sldu_operand_o          (sldu_operand_o),
    .sldu_operand_valid_o    (sldu_operand_valid_o),
    .sldu_operand_ready_i    (sldu_operand_ready_i),
    .addrgen_operand_valid_o (addrgen_operand_valid_o),
    .addrgen_operand_ready_i (addrgen_operand_ready_i),
    .sldu_red_valid_i        (sldu_red_valid_i),
    .sldu_result_gnt_opq_i   (sldu_result_gnt_opq_i),
    .sldu_alu_ready_i        (sldu_alu_ready_i),
    .sldu_mfpu_ready_i       (sldu_mfpu_ready_i),
    .sldu_result_gnt_o       (sldu_result_gnt_o),
    .sldu_alu_valid_o        (sldu_alu_valid_o),
    .sldu_mfpu_valid_o       (sldu_mfpu_valid_o),
    .pop_o                   (pop)
  );

endmodule

// File: sldu_arb/sldu_operand_router.sv
// Steers the shared operand bus and the slide unit handshakes from the FIFO head kind

`timescale 1ns/1ps

module sldu_operand_router #(
  parameter int unsigned DataWidth = 64
) (
  // Selector FIFO head
  input  logic                     head_valid_i,
  input  lane_arb_pkg::route_sel_e head_sel_i,
  // Completion strobes
  input  logic                     cmd_pop_i,
  input  logic                     alu_red_complete_i,
  input  logic                     fpu_red_complete_i,
  // Operand queue
  input  logic [DataWidth-1:0]     opq_operand_i,
  input  logic                     opq_valid_i,
  output logic                     opq_ready_o,
  // ALU reduction result
  input  logic [DataWidth-1:0]     alu_red_data_i,
  input  logic                     alu_red_valid_i,
  output logic                     alu_red_gnt_o,
  // FPU reduction result
  input  logic [DataWidth-1:0]     fpu_red_data_i,
  input  logic                     fpu_red_valid_i,
  output logic                     fpu_red_gnt_o,
  // Shared bus to the slide unit and address generator
  output logic [DataWidth-1:0]     sldu_operand_o,
  output logic                     sldu_operand_valid_o,
  input  logic                     sldu_operand_ready_i,
  output logic                     addrgen_operand_valid_o,
  input  logic                     addrgen_operand_ready_i,
  // Slide unit reduction handshakes
  input  logic                     sldu_red_valid_i,
  input  logic                     sldu_result_gnt_opq_i,
  input  logic                     sldu_alu_ready_i,
  input  logic                     sldu_mfpu_ready_i,
  output logic                     sldu_result_gnt_o,
  output logic                     sldu_alu_valid_o,
  output logic                     sldu_mfpu_valid_o,
  // Selector FIFO pop
  output logic                     pop_o
);

  always_comb begin
    // Empty FIFO means nobody owns the bus
    sldu_operand_o          = opq_operand_i;
    sldu_operand_valid_o    = 1'b0;
    addrgen_operand_valid_o = 1'b0;
    opq_ready_o             = 1'b0;
    alu_red_gnt_o           = 1'b0;
    fpu_red_gnt_o           = 1'b0;
    sldu_alu_valid_o        = 1'b0;
    sldu_mfpu_valid_o       = 1'b0;
    sldu_result_gnt_o       = 1'b0;
    pop_o                   = 1'b0;

    if (head_valid_i) begin
      case (head_sel_i)
        lane_arb_pkg::sel_sldu: begin
          sldu_operand_valid_o = opq_valid_i;
          opq_ready_o          = sldu_operand_ready_i;
          sldu_result_gnt_o    = sldu_result_gnt_opq_i;
          pop_o                = cmd_pop_i;
        end
        lane_arb_pkg::sel_addrgen: begin
          // Same queue data, but the address generator takes it
          addrgen_operand_valid_o = opq_valid_i;
          opq_ready_o             = addrgen_operand_ready_i;
          pop_o                   = cmd_pop_i;
        end
        lane_arb_pkg::sel_alu_red: begin
          sldu_operand_o       = alu_red_data_i;
          sldu_operand_valid_o = alu_red_valid_i;
          alu_red_gnt_o        = sldu_operand_ready_i;
          sldu_alu_valid_o     = sldu_red_valid_i;
          sldu_result_gnt_o    = sldu_alu_ready_i;
          pop_o                = alu_red_complete_i;
        end
        lane_arb_pkg::sel_fpu_red: begin
          sldu_operand_o       = fpu_red_data_i;
          sldu_operand_valid_o = fpu_red_valid_i;
          fpu_red_gnt_o        = sldu_operand_ready_i;
          sldu_mfpu_valid_o    = sldu_red_valid_i;
          sldu_result_gnt_o    = sldu_mfpu_ready_i;
          pop_o                = fpu_red_complete_i;
        end
        default: begin
          pop_o = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: sldu_arb/sldu_sel_fifo.sv
// In-order FIFO of route kinds; its head decides who owns the shared operand bus

`timescale 1ns/1ps

module sldu_sel_fifo #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // Write side
  input  logic                     push_i,
  input  lane_arb_pkg::route_sel_e push_sel_i,
  // Read side
  input  logic                     pop_i,
  output logic                     head_valid_o,
  output lane_arb_pkg::route_sel_e head_sel_o,
  // Status
  output logic                     full_o
);

  localparam int unsigned AddrWidth  = $clog2(FifoDepth);
  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  lane_arb_pkg::route_sel_e mem [FifoDepth];

  logic [AddrWidth-1:0]  wr_ptr_q;
  logic [AddrWidth-1:0]  rd_ptr_q;
  logic [CountWidth-1:0] count_q;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  // Depth is a power of two, so the pointers wrap by themselves
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_sel_i;
    end
  end

  assign head_sel_o   = mem[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign full_o       = (count_q == CountWidth'(FifoDepth));

endmodule

// File: sldu_arb/sldu_order_tracker.sv
// Registers issued vector ops and pushes the route kind of bus users into the selector FIFO

`timescale 1ns/1ps

module sldu_order_tracker (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // Issued vector operation
  input  logic                     vfu_op_valid_i,
  input  lane_arb_pkg::ara_op_e    vfu_op_i,
  // Towards the selector FIFO
  output logic                     push_o,
  output lane_arb_pkg::route_sel_e push_sel_o
);

  logic                  op_valid_q;
  lane_arb_pkg::ara_op_e op_q;

  ////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////

  // Cuts the path from the sequencer into the FIFO
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= vfu_op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q <= vfu_op_i;
  end

  ////////////////////////////////////////////////////////////
  // Classification
  ////////////////////////////////////////////////////////////

  always_comb begin
    push_o     = 1'b0;
    push_sel_o = lane_arb_pkg::sel_sldu;
    if (op_valid_q) begin
      case (op_q) inside
        lane_arb_pkg::vslideup, lane_arb_pkg::vslidedown: begin
          push_o     = 1'b1;
          push_sel_o = lane_arb_pkg::sel_sldu;
        end
        lane_arb_pkg::vlxe, lane_arb_pkg::vsxe: begin
          push_o     = 1'b1;
          push_sel_o = lane_arb_pkg::sel_addrgen;
        end
        [lane_arb_pkg::vredsum : lane_arb_pkg::vwredsum]: begin
          push_o     = 1'b1;
          push_sel_o = lane_arb_pkg::sel_alu_red;
        end
        [lane_arb_pkg::vfredusum : lane_arb_pkg::vfwredosum]: begin
          push_o     = 1'b1;
          push_sel_o = lane_arb_pkg::sel_fpu_red;
        end
        // Ops that never touch the shared bus
        default: begin
          push_o = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: common/lane_arb_pkg.sv
// Shared operation codes, route kinds and widths for the lane operand bus arbiter

package lane_arb_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and depths
  ////////////////////////////////////////////////////////////

  // Width of one element on the shared operand bus
  localparam int unsigned ElenWidth = 64;

  // Vector instructions that can be in flight at once
  localparam int unsigned NrVInsn = 8;

  ////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////

  // Only the codes the arbiter tells apart, plus vadd as a plain op.
  // Both reduction groups must stay contiguous, the tracker matches on ranges
  typedef enum logic [5:0] {
    vadd       = 6'd0,
    vslideup   = 6'd8,
    vslidedown = 6'd9,
    vlxe       = 6'd16,
    vsxe       = 6'd17,
    // Integer reductions
    vredsum    = 6'd24,
    vredand    = 6'd25,
    vredor     = 6'd26,
    vredxor    = 6'd27,
    vredminu   = 6'd28,
    vredmin    = 6'd29,
    vredmaxu   = 6'd30,
    vredmax    = 6'd31,
    vwredsumu  = 6'd32,
    vwredsum   = 6'd33,
    // Floating-point reductions
    vfredusum  = 6'd40,
    vfredosum  = 6'd41,
    vfredmin   = 6'd42,
    vfredmax   = 6'd43,
    vfwredusum = 6'd44,
    vfwredosum = 6'd45
  } ara_op_e;

  // Which consumer or producer owns the operand bus
  typedef enum logic [1:0] {
    sel_sldu    = 2'd0,
    sel_addrgen = 2'd1,
    sel_alu_red = 2'd2,
    sel_fpu_red = 2'd3
  } route_sel_e;

endpackage
